// ==== common/led_matrix_pkg.sv ====
/* panel geometry, timing constants, command codes and the pixel type
   shared by the led matrix driver blocks; imported with a wildcard */
package led_matrix_pkg;

    // panel geometry
    localparam int COLS         = 8;
    localparam int ROWS         = 8;
    localparam int SCAN_ROWS    = ROWS / 2;          // rows driven as top/bottom pairs
    localparam int COL_BITS     = $clog2(COLS);
    localparam int ROW_BITS     = $clog2(ROWS);
    localparam int SCAN_BITS    = $clog2(SCAN_ROWS);
    localparam int FB_ADDR_BITS = ROW_BITS + COL_BITS; // row * COLS + column
    localparam int FB_DEPTH     = COLS * ROWS;

    // colour depth, one plane per bit
    localparam int BRIGHT_BITS = 2;
    localparam int PLANE_BITS  = $clog2(BRIGHT_BITS);

    // uart timing
    localparam int TICKS_PER_BIT = 8;
    localparam int TICK_BITS     = $clog2(TICKS_PER_BIT);

    // scan timing, all in clk_root cycles
    localparam int PIXEL_PERIOD = 8;                 // per shifted column
    localparam int LATCH_CYCLES = 2;
    localparam int PLANE_BASE   = 16;                // plane p shows PLANE_BASE << p
    localparam int DISP_BITS    = $clog2(PLANE_BASE) + BRIGHT_BITS;

    // command opcodes
    localparam logic [7:0] CMD_PIXEL  = 8'h50;       // x, y, colour
    localparam logic [7:0] CMD_FILL   = 8'h46;       // colour
    localparam logic [7:0] CMD_BRIGHT = 8'h42;       // plane mask
    localparam logic [7:0] CMD_RGB    = 8'h43;       // channel mask

    typedef struct packed {
        logic [BRIGHT_BITS-1:0] blue;
        logic [BRIGHT_BITS-1:0] green;
        logic [BRIGHT_BITS-1:0] red;
    } pixel_t;

endpackage

// ==== common/scan_if.sv ====
/* scan position and load strobe from the scan engine to the fetch stage */
`timescale 1ns/1ps

interface scan_if
    import led_matrix_pkg::*;
();
    logic [COL_BITS-1:0]   column;
    logic [SCAN_BITS-1:0]  row_pair;
    logic [PLANE_BITS-1:0] plane;
    logic                  load_start;   // one cycle per column

    modport scan (
        output column, row_pair, plane, load_start
    );

    modport fetch (
        input column, row_pair, plane, load_start
    );
endinterface

// ==== control/uart_rx.sv ====
/* 8N1 receiver for the command byte stream
   pulses rx_valid for one cycle per good frame, no back-pressure */
`timescale 1ns/1ps

module uart_rx
    import led_matrix_pkg::*;
(
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic       rx_line,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic [TICK_BITS-1:0] tick;
    logic [2:0]           bit_idx;
    logic [7:0]           shift_reg;

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            state    <= RX_IDLE;
            tick     <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rx_line;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            tick     <= tick + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick <= '0;
                    if (!rx_sync) state <= RX_START;
                end
                RX_START: if (tick == TICK_BITS'(TICKS_PER_BIT / 2 - 1)) begin
                    tick    <= '0;
                    bit_idx <= '0;
                    state   <= rx_sync ? RX_IDLE : RX_DATA;  // glitch, not a start bit
                end
                RX_DATA: if (tick == TICK_BITS'(TICKS_PER_BIT - 1)) begin
                    tick    <= '0;
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (tick == TICK_BITS'(TICKS_PER_BIT - 1)) begin
                    rx_valid <= rx_sync;       // framing error drops the byte
                    state    <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data path, lsb first
    always_ff @(posedge clk_root) begin
        if (state == RX_DATA && tick == TICK_BITS'(TICKS_PER_BIT - 1))
            shift_reg <= {rx_sync, shift_reg[7:1]};
        if (state == RX_STOP && tick == TICK_BITS'(TICKS_PER_BIT - 1))
            rx_data <= shift_reg;
    end
endmodule

// ==== control/command_decoder.sv ====
/* byte command decoder: pixel, fill, plane mask and channel mask commands
   writes the framebuffer and holds the two enable masks */
`timescale 1ns/1ps

module command_decoder
    import led_matrix_pkg::*;
(
    input  logic                    clk_root,
    input  logic                    rst_n,
    input  logic [7:0]              rx_data,
    input  logic                    rx_valid,
    output logic [FB_ADDR_BITS-1:0] wr_addr,
    output pixel_t                  wr_data,
    output logic                    wr_en,
    output logic [2:0]              rgb_enable,
    output logic [BRIGHT_BITS-1:0]  bright_enable
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARGS,
        ST_FILL
    } dec_state_t;

    dec_state_t          state;
    logic [7:0]          opcode;
    logic [1:0]          arg_idx;
    logic [COL_BITS-1:0] pos_x;
    logic [ROW_BITS-1:0] pos_y;

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            opcode        <= '0;
            arg_idx       <= '0;
            pos_x         <= '0;
            pos_y         <= '0;
            wr_addr       <= '0;
            wr_data       <= '0;
            wr_en         <= 1'b0;
            rgb_enable    <= '1;
            bright_enable <= '1;
        end else begin
            wr_en <= 1'b0;
            case (state)
                ST_IDLE: if (rx_valid) begin
                    case (rx_data)
                        CMD_PIXEL, CMD_FILL, CMD_BRIGHT, CMD_RGB: begin
                            opcode  <= rx_data;
                            arg_idx <= '0;
                            state   <= ST_ARGS;
                        end
                        default: ;            // stray byte, ignored
                    endcase
                end
                ST_ARGS: if (rx_valid) begin
                    arg_idx <= arg_idx + 2'd1;
                    state   <= ST_IDLE;       // single-argument commands end here
                    case (opcode)
                        CMD_PIXEL: begin
                            if (arg_idx != 2'd2) state <= ST_ARGS;
                            if (arg_idx == 2'd0) pos_x <= rx_data[COL_BITS-1:0];
                            if (arg_idx == 2'd1) pos_y <= rx_data[ROW_BITS-1:0];
                            if (arg_idx == 2'd2) begin
                                wr_addr <= {pos_y, pos_x};  // coordinates wrap
                                wr_data <= pixel_t'(rx_data[$bits(pixel_t)-1:0]);
                                wr_en   <= 1'b1;
                            end
                        end
                        CMD_FILL: begin
                            wr_addr <= '0;
                            wr_data <= pixel_t'(rx_data[$bits(pixel_t)-1:0]);
                            wr_en   <= 1'b1;
                            state   <= ST_FILL;
                        end
                        CMD_BRIGHT: bright_enable <= rx_data[BRIGHT_BITS-1:0];
                        CMD_RGB:    rgb_enable    <= rx_data[2:0];
                        default: ;
                    endcase
                end
                ST_FILL: begin
                    // one word per cycle, bytes arriving meanwhile are dropped
                    if (wr_addr == FB_ADDR_BITS'(FB_DEPTH - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        wr_addr <= wr_addr + 1'b1;
                        wr_en   <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end
endmodule

// ==== hdl/framebuffer.sv ====
/* simple dual-port pixel memory
   one write port from the decoder, one registered read port for the fetch */
`timescale 1ns/1ps

module framebuffer
    import led_matrix_pkg::*;
(
    input  logic                    clk_root,
    input  logic [FB_ADDR_BITS-1:0] wr_addr,
    input  pixel_t                  wr_data,
    input  logic                    wr_en,
    input  logic [FB_ADDR_BITS-1:0] rd_addr,
    input  logic                    rd_en,
    output pixel_t                  rd_data
);
    pixel_t mem [FB_DEPTH];

    always_ff @(posedge clk_root) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // read data one cycle after rd_en
    always_ff @(posedge clk_root) begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end
endmodule

// ==== display/matrix_scan.sv ====
/* panel sequencer: shift a row pair's columns, latch, then display the plane
   display time doubles with each plane for binary-coded modulation */
`timescale 1ns/1ps

module matrix_scan
    import led_matrix_pkg::*;
(
    input  logic                 clk_root,
    input  logic                 rst_n,
    scan_if.scan                 scan,
    output logic [SCAN_BITS-1:0] row_addr,
    output logic                 clk_pixel,
    output logic                 row_latch,
    output logic                 output_enable_n
);
    typedef enum logic [1:0] {
        ST_SHIFT,
        ST_LATCH,
        ST_DISPLAY
    } scan_state_t;

    scan_state_t           state;
    logic [DISP_BITS-1:0]  phase;       // cycles within column, latch or display
    logic [COL_BITS-1:0]   column;
    logic [PLANE_BITS-1:0] plane;
    logic [SCAN_BITS-1:0]  row_pair;
    logic [DISP_BITS-1:0]  dwell_last;

    assign dwell_last = DISP_BITS'((PLANE_BASE << plane) - 1);

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_SHIFT;
            phase    <= '0;
            column   <= '0;
            plane    <= '0;
            row_pair <= '0;
            row_addr <= '0;
        end else begin
            phase <= phase + 1'b1;
            case (state)
                ST_SHIFT: if (phase == DISP_BITS'(PIXEL_PERIOD - 1)) begin
                    phase  <= '0;
                    column <= column + 1'b1;
                    if (column == COL_BITS'(COLS - 1))
                        state <= ST_LATCH;
                end
                ST_LATCH: begin
                    if (phase == '0)
                        row_addr <= row_pair;   // switch rows under the latch
                    if (phase == DISP_BITS'(LATCH_CYCLES - 1)) begin
                        phase <= '0;
                        state <= ST_DISPLAY;
                    end
                end
                ST_DISPLAY: if (phase == dwell_last) begin
                    phase <= '0;
                    state <= ST_SHIFT;
                    plane <= plane + 1'b1;
                    if (plane == PLANE_BITS'(BRIGHT_BITS - 1)) begin
                        plane    <= '0;
                        row_pair <= row_pair + 1'b1;
                    end
                end
                default: state <= ST_SHIFT;
            endcase
        end
    end

    assign scan.column     = column;
    assign scan.row_pair   = row_pair;
    assign scan.plane      = plane;
    assign scan.load_start = (state == ST_SHIFT) && (phase == '0);

    // pixel clock high for the last two cycles of each column
    assign clk_pixel       = (state == ST_SHIFT) && (phase >= DISP_BITS'(PIXEL_PERIOD - 2));
    assign row_latch       = (state == ST_LATCH);
    assign output_enable_n = (state != ST_DISPLAY);
endmodule

// ==== display/framebuffer_fetch.sv ====
/* fetches the top and bottom pixel for each shifted column
   and reduces them to the masked rgb bits of the current plane */
`timescale 1ns/1ps

module framebuffer_fetch
    import led_matrix_pkg::*;
(
    input  logic                    clk_root,
    input  logic                    rst_n,
    scan_if.fetch                   scan,
    output logic [FB_ADDR_BITS-1:0] rd_addr,
    output logic                    rd_en,
    input  pixel_t                  rd_data,
    input  logic [2:0]              rgb_enable,
    input  logic [BRIGHT_BITS-1:0]  bright_enable,
    output logic [2:0]              rgb_top,
    output logic [2:0]              rgb_bottom
);
    logic [2:0]          step;          // load_start delayed by 1, 2 and 3 cycles
    logic [ROW_BITS-1:0] top_row;
    logic [ROW_BITS-1:0] bottom_row;
    pixel_t              top_px;
    pixel_t              bottom_px;

    // bit order red, green, blue from lsb
    function automatic logic [2:0] plane_rgb(input pixel_t px,
                                             input logic [PLANE_BITS-1:0] plane);
        logic [2:0] bits;
        bits = {px.blue[plane], px.green[plane], px.red[plane]};
        return bits & rgb_enable & {3{bright_enable[plane]}};
    endfunction

    assign top_row    = ROW_BITS'(scan.row_pair);
    assign bottom_row = top_row + ROW_BITS'(SCAN_ROWS);

    // top read on the strobe, bottom read the cycle after
    assign rd_en   = scan.load_start | step[0];
    assign rd_addr = scan.load_start ? {top_row, scan.column} : {bottom_row, scan.column};

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            step       <= '0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            step <= {step[1:0], scan.load_start};
            if (step[2]) begin
                rgb_top    <= plane_rgb(top_px, scan.plane);
                rgb_bottom <= plane_rgb(bottom_px, scan.plane);
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (step[0]) top_px    <= rd_data;
        if (step[1]) bottom_px <= rd_data;
    end
endmodule

// ==== hdl/led_panel_top.sv ====
/* top level of the hub75 matrix driver
   uart commands in, panel shift, latch and enable lines out */
`timescale 1ns/1ps

module led_panel_top
    import led_matrix_pkg::*;
(
    input  logic                 clk_root,
    input  logic                 rst_n,
    input  logic                 uart_rx,
    output logic [2:0]           rgb_top,
    output logic [2:0]           rgb_bottom,
    output logic [SCAN_BITS-1:0] row_addr,
    output logic                 clk_pixel,
    output logic                 row_latch,
    output logic                 output_enable_n
);
    logic [7:0]              rx_data;
    logic                    rx_valid;
    logic [FB_ADDR_BITS-1:0] wr_addr;
    pixel_t                  wr_data;
    logic                    wr_en;
    logic [FB_ADDR_BITS-1:0] rd_addr;
    logic                    rd_en;
    pixel_t                  rd_data;
    logic [2:0]              rgb_enable;
    logic [BRIGHT_BITS-1:0]  bright_enable;

    scan_if scan_bus ();

    uart_rx u_uart_rx (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .rx_line  (uart_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    command_decoder u_decoder (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_en         (wr_en),
        .rgb_enable    (rgb_enable),
        .bright_enable (bright_enable)
    );

    framebuffer u_framebuffer (
        .clk_root (clk_root),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_en    (wr_en),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en),
        .rd_data  (rd_data)
    );

    matrix_scan u_scan (
        .clk_root        (clk_root),
        .rst_n           (rst_n),
        .scan            (scan_bus.scan),
        .row_addr        (row_addr),
        .clk_pixel       (clk_pixel),
        .row_latch       (row_latch),
        .output_enable_n (output_enable_n)
    );

    framebuffer_fetch u_fetch (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .scan          (scan_bus.fetch),
        .rd_addr       (rd_addr),
        .rd_en         (rd_en),
        .rd_data       (rd_data),
        .rgb_enable    (rgb_enable),
        .bright_enable (bright_enable),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom)
    );
endmodule

// ==== bench/led_panel_assertions.sv ====
/* control line rules of the scan engine, bound into matrix_scan */
`timescale 1ns/1ps

module led_panel_assertions
    import led_matrix_pkg::*;
(
    input logic                 clk_root,
    input logic                 rst_n,
    input logic [SCAN_BITS-1:0] row_addr,
    input logic                 clk_pixel,
    input logic                 row_latch,
    input logic                 output_enable_n
);
    // latching into a lit row would flash the next row's data
    latch_while_dark: assert property (@(posedge clk_root) disable iff (!rst_n)
        row_latch |-> output_enable_n)
        else $error("row_latch high while output_enable_n is low");

    pixel_clock_quiet: assert property (@(posedge clk_root) disable iff (!rst_n)
        row_latch |-> !clk_pixel)
        else $error("clk_pixel high during row_latch");

    row_change_in_latch: assert property (@(posedge clk_root) disable iff (!rst_n)
        (row_addr != $past(row_addr)) |-> $past(row_latch))
        else $error("row_addr changed outside row_latch");
endmodule

bind matrix_scan led_panel_assertions u_assertions (
    .clk_root        (clk_root),
    .rst_n           (rst_n),
    .row_addr        (row_addr),
    .clk_pixel       (clk_pixel),
    .row_latch       (row_latch),
    .output_enable_n (output_enable_n)
);

// ==== bench/panel_checker.sv ====
/* watches the panel outputs, rebuilds each shifted plane and compares it
   with the reference frame; a request arms one full-frame comparison */
`timescale 1ns/1ps

module panel_checker
    import led_matrix_pkg::*;
(
    input  logic                   clk_root,
    input  logic                   rst_n,
    input  logic [2:0]             rgb_top,
    input  logic [2:0]             rgb_bottom,
    input  logic [SCAN_BITS-1:0]   row_addr,
    input  logic                   clk_pixel,
    input  logic                   row_latch,
    input  pixel_t                 ref_frame [FB_DEPTH],
    input  logic [2:0]             ref_rgb,
    input  logic [BRIGHT_BITS-1:0] ref_bright,
    input  logic                   frame_req,
    output logic                   frame_done,
    output int                     value_errors,
    output int                     order_errors,
    output logic [5:0]             first_expected,   // {top, bottom}
    output logic [5:0]             first_actual,
    output int                     first_pair,
    output int                     first_plane,
    output int                     first_col
);
    logic [2:0]            top_seen [COLS];
    logic [2:0]            bottom_seen [COLS];
    logic                  pixel_q;
    logic                  latch_q;
    logic                  armed;
    logic                  row_pending;   // row_addr still to be checked
    int                    col_count;
    int                    latch_count;   // latches since reset
    int                    latches_left;
    logic [PLANE_BITS-1:0] plane;
    logic [SCAN_BITS-1:0]  pair;

    // displayed bits for one pixel, red in bit 0
    function automatic logic [2:0] expected_bits(input pixel_t px,
                                                 input logic [PLANE_BITS-1:0] pl);
        logic [2:0] colour;
        colour = {px.blue[pl], px.green[pl], px.red[pl]};
        if (!ref_bright[pl])
            colour = 3'b000;              // whole plane dark
        return colour & ref_rgb;
    endfunction

    function automatic void compare_plane();
        logic [5:0] exp_bits;
        logic [5:0] act_bits;
        for (int c = 0; c < COLS; c++) begin
            exp_bits = {expected_bits(ref_frame[FB_ADDR_BITS'(int'(pair) * COLS + c)], plane),
                        expected_bits(ref_frame[FB_ADDR_BITS'((int'(pair) + SCAN_ROWS) * COLS
                                                             + c)], plane)};
            act_bits = {top_seen[COL_BITS'(c)], bottom_seen[COL_BITS'(c)]};
            if (exp_bits !== act_bits) begin
                if (value_errors == 0) begin
                    first_expected = exp_bits;
                    first_actual   = act_bits;
                    first_pair     = int'(pair);
                    first_plane    = int'(plane);
                    first_col      = c;
                end
                value_errors++;
            end
        end
        if (col_count != COLS)
            order_errors++;               // shifted too few or too many columns
    endfunction

    always @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            pixel_q      = 1'b0;
            latch_q      = 1'b0;
            armed        = 1'b0;
            row_pending  = 1'b0;
            col_count    = 0;
            latch_count  = 0;
            latches_left = 0;
            plane        = '0;
            pair         = '0;
            frame_done   = 1'b0;
            value_errors = 0;
            order_errors = 0;
        end else begin
            frame_done = 1'b0;
            if (clk_pixel && !pixel_q) begin
                if (col_count < COLS) begin
                    top_seen[COL_BITS'(col_count)]    = rgb_top;
                    bottom_seen[COL_BITS'(col_count)] = rgb_bottom;
                end
                col_count++;
            end
            if (!row_latch && latch_q && row_pending) begin
                row_pending = 1'b0;
                if (row_addr !== pair)
                    order_errors++;
                frame_done = (latches_left == 0);   // last row of the frame checked
            end
            if (row_latch && !latch_q) begin
                plane = PLANE_BITS'(latch_count % BRIGHT_BITS);
                pair  = SCAN_BITS'((latch_count / BRIGHT_BITS) % SCAN_ROWS);
                if (latches_left > 0) begin
                    compare_plane();
                    row_pending  = 1'b1;
                    latches_left = latches_left - 1;
                end
                if (armed) begin          // planes shifted from here on are fresh
                    armed        = 1'b0;
                    latches_left = SCAN_ROWS * BRIGHT_BITS;
                end
                col_count   = 0;
                latch_count = latch_count + 1;
            end
            if (frame_req) begin
                armed        = 1'b1;
                value_errors = 0;
                order_errors = 0;
            end
            pixel_q = clk_pixel;
            latch_q = row_latch;
        end
    end
endmodule

// ==== bench/tb_led_panel.sv ====
/* testbench for the led panel driver: sends the command table over uart,
   keeps a reference frame and has panel_checker compare whole frames */
`timescale 1ns/1ps

module tb_led_panel
    import led_matrix_pkg::*;
();
    typedef enum {FX_FILL, FX_PIXEL, FX_RGB, FX_BRIGHT, FX_NONE} effect_t;

    logic                   clk_root;
    logic                   rst_n;
    logic                   uart_line;
    logic [2:0]             rgb_top;
    logic [2:0]             rgb_bottom;
    logic [SCAN_BITS-1:0]   row_addr;
    logic                   clk_pixel;
    logic                   row_latch;
    logic                   output_enable_n;

    // reference model of frame and masks
    pixel_t                 ref_frame [FB_DEPTH];
    logic [2:0]             ref_rgb;
    logic [BRIGHT_BITS-1:0] ref_bright;

    logic       frame_req;
    logic       frame_done;
    int         value_errors;
    int         order_errors;
    logic [5:0] first_expected;
    logic [5:0] first_actual;
    int         first_pair;
    int         first_plane;
    int         first_col;

    // command table, one entry per test
    string           tbl_name [$];
    effect_t         tbl_effect [$];
    int              tbl_len [$];
    logic [3:0][7:0] tbl_bytes [$];

    int          rx_count;
    int          pass_count;
    int          fail_count;

    led_panel_top DUT (
        .clk_root        (clk_root),
        .rst_n           (rst_n),
        .uart_rx         (uart_line),
        .rgb_top         (rgb_top),
        .rgb_bottom      (rgb_bottom),
        .row_addr        (row_addr),
        .clk_pixel       (clk_pixel),
        .row_latch       (row_latch),
        .output_enable_n (output_enable_n)
    );

    panel_checker u_checker (
        .clk_root        (clk_root),
        .rst_n           (rst_n),
        .rgb_top         (rgb_top),
        .rgb_bottom      (rgb_bottom),
        .row_addr        (row_addr),
        .clk_pixel       (clk_pixel),
        .row_latch       (row_latch),
        .ref_frame       (ref_frame),
        .ref_rgb         (ref_rgb),
        .ref_bright      (ref_bright),
        .frame_req       (frame_req),
        .frame_done      (frame_done),
        .value_errors    (value_errors),
        .order_errors    (order_errors),
        .first_expected  (first_expected),
        .first_actual    (first_actual),
        .first_pair      (first_pair),
        .first_plane     (first_plane),
        .first_col       (first_col)
    );

    always #5 clk_root = ~clk_root;

    always @(posedge clk_root) begin
        if (DUT.rx_valid)
            rx_count <= rx_count + 1;     // bytes accepted by the receiver
    end

    function automatic void add_entry(input string name, input effect_t fx, input int len,
                                      input logic [7:0] b0, input logic [7:0] b1,
                                      input logic [7:0] b2, input logic [7:0] b3);
        tbl_name.push_back(name);
        tbl_effect.push_back(fx);
        tbl_len.push_back(len);
        tbl_bytes.push_back({b3, b2, b1, b0});
    endfunction

    // random colour that differs from the one given
    function automatic logic [7:0] colour_not(input logic [7:0] avoid);
        return {2'b00, avoid[5:0] ^ 6'(1 + $urandom % 63)};
    endfunction

    function automatic void build_table();
        logic [7:0] fill_c;
        fill_c = {2'b00, 6'($urandom) | 6'b001011};   // red and green[1] always lit
        add_entry("fill_random", FX_FILL, 2, CMD_FILL, fill_c, 8'h00, 8'h00);
        add_entry("pixel_top_left", FX_PIXEL, 4, CMD_PIXEL, 8'd0, 8'd0, colour_not(fill_c));
        add_entry("pixel_mid_top", FX_PIXEL, 4, CMD_PIXEL, 8'd3, 8'd2, colour_not(fill_c));
        add_entry("pixel_bottom_edge", FX_PIXEL, 4, CMD_PIXEL, 8'd7, 8'd6, colour_not(fill_c));
        add_entry("pixel_wrapped", FX_PIXEL, 4, CMD_PIXEL, 8'h0a, 8'h0d, colour_not(fill_c));
        add_entry("rgb_no_green", FX_RGB, 2, CMD_RGB, 8'h05, 8'h00, 8'h00);
        add_entry("bright_plane0_only", FX_BRIGHT, 2, CMD_BRIGHT, 8'h01, 8'h00, 8'h00);
        add_entry("stray_bytes", FX_NONE, 3, 8'h00, 8'ha5, 8'h7e, 8'h00);
        add_entry("rgb_all_on", FX_RGB, 2, CMD_RGB, 8'h07, 8'h00, 8'h00);
        add_entry("bright_all_on", FX_BRIGHT, 2, CMD_BRIGHT, 8'h03, 8'h00, 8'h00);
        add_entry("fill_second", FX_FILL, 2, CMD_FILL, colour_not(fill_c), 8'h00, 8'h00);
    endfunction

    // command rules: fill all, pixel at y*COLS+x with wrap, masks from low bits
    function automatic void update_model(input int idx);
        int x;
        int y;
        x = int'(tbl_bytes[idx][1]) % COLS;
        y = int'(tbl_bytes[idx][2]) % ROWS;
        case (tbl_effect[idx])
            FX_FILL:
                for (int a = 0; a < FB_DEPTH; a++)
                    ref_frame[FB_ADDR_BITS'(a)] = pixel_t'(tbl_bytes[idx][1][5:0]);
            FX_PIXEL:  ref_frame[FB_ADDR_BITS'(y * COLS + x)] = pixel_t'(tbl_bytes[idx][3][5:0]);
            FX_RGB:    ref_rgb = tbl_bytes[idx][1][2:0];
            FX_BRIGHT: ref_bright = tbl_bytes[idx][1][BRIGHT_BITS-1:0];
            default: ;                    // unknown bytes change nothing
        endcase
    endfunction

    task automatic drive_bit(input logic value);
        uart_line = value;
        repeat (TICKS_PER_BIT) @(posedge clk_root);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] value);
        drive_bit(1'b0);
        for (int b = 0; b < 8; b++)
            drive_bit(value[3'(b)]);      // lsb first
        drive_bit(1'b1);
        drive_bit(1'b1);                  // idle gap
    endtask

    task automatic wait_bytes(input int target, output bit ok);
        for (int n = 0; n < 40 && rx_count < target; n++) begin
            @(posedge clk_root);
            #1;
        end
        ok = (rx_count >= target);
    endtask

    // a fill keeps wr_en high, so two quiet cycles mean the writes are done
    task automatic wait_write_idle(output bit ok);
        int quiet;
        quiet = 0;
        for (int n = 0; n < 200 && quiet < 2; n++) begin
            @(posedge clk_root);
            #1;
            quiet = DUT.wr_en ? 0 : quiet + 1;
        end
        ok = (quiet >= 2);
    endtask

    task automatic wait_frame(output bit ok);
        frame_req = 1'b1;
        @(posedge clk_root);
        #1;
        frame_req = 1'b0;
        ok = 1'b0;
        for (int n = 0; n < 3000 && !ok; n++) begin
            @(posedge clk_root);
            #1;
            ok = frame_done;
        end
    endtask

    task automatic check_reset();
        int         bad;
        logic [2:0] seen;
        bad  = 0;
        seen = 3'b100;
        for (int n = 0; n < 10; n++) begin
            @(posedge clk_root);
            #1;
            if ({output_enable_n, clk_pixel, row_latch} !== 3'b100) begin
                if (bad == 0)
                    seen = {output_enable_n, clk_pixel, row_latch};
                bad++;
            end
            if (n == 7)
                rst_n = 1'b1;             // released after 8 cycles
        end
        if (bad == 0) begin
            $display("ok   reset_idle");
            pass_count++;
        end else begin
            $display("Fail reset_idle: expected oe_n,clk_pixel,row_latch %b actual %b",
                     3'b100, seen);
            fail_count++;
        end
    endtask

    task automatic run_test(input int idx);
        int target;
        bit ok;
        target = rx_count + tbl_len[idx];
        for (int k = 0; k < tbl_len[idx]; k++)
            send_byte(tbl_bytes[idx][2'(k)]);
        wait_bytes(target, ok);
        if (ok)
            wait_write_idle(ok);
        if (!ok) begin
            $display("%s: the decoder did not take the command in time", tbl_name[idx]);
            fail_count++;
            return;
        end
        update_model(idx);
        wait_frame(ok);
        if (!ok) begin
            $display("%s: no complete frame was seen on the panel in time", tbl_name[idx]);
            fail_count++;
        end else if (order_errors != 0) begin
            $display("%s: panel sequence broken, %0d latches had a wrong column count or row",
                     tbl_name[idx], order_errors);
            fail_count++;
        end else if (value_errors != 0) begin
            $display("Fail %s: expected %b actual %b (top,bottom) pair %0d plane %0d col %0d",
                     tbl_name[idx], first_expected, first_actual, first_pair, first_plane,
                     first_col);
            fail_count++;
        end else begin
            $display("ok   %s", tbl_name[idx]);
            pass_count++;
        end
    endtask

    initial begin
        clk_root   = 1'b0;
        rst_n      = 1'b0;
        uart_line  = 1'b1;
        frame_req  = 1'b0;
        rx_count   = 0;
        pass_count = 0;
        fail_count = 0;
        ref_rgb    = '1;
        ref_bright = '1;
        for (int a = 0; a < FB_DEPTH; a++)
            ref_frame[FB_ADDR_BITS'(a)] = '0;
        void'($urandom(90));
        build_table();
        check_reset();
        for (int i = 0; i < tbl_name.size(); i++)
            run_test(i);
        $display("%0d tests, %0d passed, %0d failed", pass_count + fail_count, pass_count,
                 fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end
endmodule

// ==== project.f ====
common/led_matrix_pkg.sv
common/scan_if.sv
control/uart_rx.sv
control/command_decoder.sv
hdl/framebuffer.sv
display/matrix_scan.sv
display/framebuffer_fetch.sv
hdl/led_panel_top.sv
bench/led_panel_assertions.sv
bench/panel_checker.sv
bench/tb_led_panel.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the led panel testbench with verilator, run it, check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_led_panel \
    -f project.f --Mdir obj_dir -o tb_led_panel
./obj_dir/tb_led_panel | tee sim.log
if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
